// File: design/ooo_cfg_pkg.sv
`default_nettype none

// machine sizes shared by every block
package ooo_cfg_pkg;

	// operand and result word
	localparam int data_width = 32;
	typedef logic [data_width-1:0] data_t;

	// architectural register file, r0 reads zero
	localparam int arch_regs = 16;
	typedef logic [$clog2(arch_regs)-1:0] areg_t;

endpackage

`default_nettype wire

// File: design/ooo_uop_pkg.sv
`default_nettype none

// micro-op encoding
package ooo_uop_pkg;

	// 3-bit opcode, codes 6 and 7 unused
	typedef enum logic [2:0] {
		op_add  = 3'd0,
		op_sub  = 3'd1,
		op_and  = 3'd2,
		op_xor  = 3'd3,
		op_addi = 3'd4,
		op_li   = 3'd5
	} alu_op_t;

	// register-register ops read rs2, the rest take imm
	function automatic logic uses_rs2(alu_op_t op);
		return op inside {op_add, op_sub, op_and, op_xor};
	endfunction

	// only li ignores rs1
	function automatic logic uses_rs1(alu_op_t op);
		return op != op_li;
	endfunction

endpackage

`default_nettype wire

// File: design/alu_pipe.sv
`default_nettype none

module alu_pipe #(
	parameter int rob_depth = 8
) (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         issue_valid,
	input  ooo_uop_pkg::alu_op_t         issue_op,
	input  logic [$clog2(rob_depth)-1:0] issue_tag,
	input  ooo_cfg_pkg::data_t           issue_a,
	input  ooo_cfg_pkg::data_t           issue_b,
	output logic                         cdb_valid,
	output logic [$clog2(rob_depth)-1:0] cdb_tag,
	output ooo_cfg_pkg::data_t           cdb_data
);
	import ooo_cfg_pkg::*;
	import ooo_uop_pkg::*;

	localparam int tag_w = $clog2(rob_depth);

	// stage 1 holds the issued op
	logic             s1_valid;
	alu_op_t          s1_op;
	logic [tag_w-1:0] s1_tag;
	data_t            s1_a;
	data_t            s1_b;
	data_t            result;

	always_comb begin
		case (s1_op)
			op_add, op_addi: result = s1_a + s1_b;
			op_sub:          result = s1_a - s1_b;
			op_and:          result = s1_a & s1_b;
			op_xor:          result = s1_a ^ s1_b;
			op_li:           result = s1_b;
			default:         result = '0;
		endcase
	end

	// valid bits move with the data, no stall
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			cdb_valid <= 1'b0;
		end else begin
			s1_valid  <= issue_valid;
			cdb_valid <= s1_valid;
		end
	end

	// stage 2 drives the cdb
	always_ff @(posedge clock) begin
		s1_op    <= issue_op;
		s1_tag   <= issue_tag;
		s1_a     <= issue_a;
		s1_b     <= issue_b;
		cdb_tag  <= s1_tag;
		cdb_data <= result;
	end

endmodule

`default_nettype wire

// File: design/reservation_station.sv
`default_nettype none

module reservation_station #(
	parameter int rs_depth  = 4,
	parameter int rob_depth = 8
) (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         alloc,
	input  ooo_uop_pkg::alu_op_t         alloc_op,
	input  logic [$clog2(rob_depth)-1:0] alloc_tag,
	input  logic                         src1_ready,
	input  logic [$clog2(rob_depth)-1:0] src1_tag,
	input  ooo_cfg_pkg::data_t           src1_data,
	input  logic                         src2_ready,
	input  logic [$clog2(rob_depth)-1:0] src2_tag,
	input  ooo_cfg_pkg::data_t           src2_data,
	input  logic                         cdb_valid,
	input  logic [$clog2(rob_depth)-1:0] cdb_tag,
	input  ooo_cfg_pkg::data_t           cdb_data,
	output logic                         full,
	output logic                         issue_valid,
	output ooo_uop_pkg::alu_op_t         issue_op,
	output logic [$clog2(rob_depth)-1:0] issue_tag,
	output ooo_cfg_pkg::data_t           issue_a,
	output ooo_cfg_pkg::data_t           issue_b
);
	import ooo_cfg_pkg::*;
	import ooo_uop_pkg::*;

	localparam int tag_w = $clog2(rob_depth);
	localparam int idx_w = $clog2(rs_depth);
	localparam int cnt_w = $clog2(rs_depth + 1);

	////////////////////////////////////////
	// shifting queue, slot 0 is oldest
	logic [cnt_w-1:0]    count;
	alu_op_t             e_op   [rs_depth];
	logic [tag_w-1:0]    e_dst  [rs_depth];
	logic [rs_depth-1:0] e_rdy1;
	logic [rs_depth-1:0] e_rdy2;
	logic [tag_w-1:0]    e_tag1 [rs_depth];
	logic [tag_w-1:0]    e_tag2 [rs_depth];
	data_t               e_val1 [rs_depth];
	data_t               e_val2 [rs_depth];

	// sources after this cycle's cdb snoop
	logic [rs_depth-1:0] w_rdy1;
	logic [rs_depth-1:0] w_rdy2;
	data_t               w_val1 [rs_depth];
	data_t               w_val2 [rs_depth];

	logic [idx_w-1:0]    sel;
	logic [idx_w-1:0]    take   [rs_depth];
	logic [cnt_w-1:0]    ins_pos;

	assign full    = (count == cnt_w'(rs_depth));
	assign ins_pos = count - cnt_w'(issue_valid);

	// wakeup
	always_comb begin
		for (int i = 0; i < rs_depth; i++) begin
			w_rdy1[i] = e_rdy1[i] || (cdb_valid && e_tag1[i] == cdb_tag);
			w_rdy2[i] = e_rdy2[i] || (cdb_valid && e_tag2[i] == cdb_tag);
			w_val1[i] = e_rdy1[i] ? e_val1[i] : cdb_data;
			w_val2[i] = e_rdy2[i] ? e_val2[i] : cdb_data;
		end
	end

	// oldest entry with both sources held, registered state only
	always_comb begin
		issue_valid = 1'b0;
		sel         = '0;
		for (int i = rs_depth - 1; i >= 0; i--) begin
			if (i < count && e_rdy1[i] && e_rdy2[i]) begin
				issue_valid = 1'b1;
				sel         = idx_w'(i);
			end
		end
	end

	assign issue_op  = e_op[sel];
	assign issue_tag = e_dst[sel];
	assign issue_a   = e_val1[sel];
	assign issue_b   = e_val2[sel];

	// close the gap left by the issued slot
	always_comb begin
		for (int i = 0; i < rs_depth; i++) begin
			take[i] = idx_w'(i);
			if (issue_valid && i >= sel && i < rs_depth - 1) begin
				take[i] = idx_w'(i + 1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			count <= count + cnt_w'(alloc) - cnt_w'(issue_valid);
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < rs_depth; i++) begin
			if (alloc && i == ins_pos) begin
				// new entry lands behind all survivors
				e_op[i]   <= alloc_op;
				e_dst[i]  <= alloc_tag;
				e_rdy1[i] <= src1_ready;
				e_tag1[i] <= src1_tag;
				e_val1[i] <= src1_data;
				e_rdy2[i] <= src2_ready;
				e_tag2[i] <= src2_tag;
				e_val2[i] <= src2_data;
			end else begin
				e_op[i]   <= e_op[take[i]];
				e_dst[i]  <= e_dst[take[i]];
				e_rdy1[i] <= w_rdy1[take[i]];
				e_tag1[i] <= e_tag1[take[i]];
				e_val1[i] <= w_val1[take[i]];
				e_rdy2[i] <= w_rdy2[take[i]];
				e_tag2[i] <= e_tag2[take[i]];
				e_val2[i] <= w_val2[take[i]];
			end
		end
	end

	a_issue_ready: assert property (@(posedge clock) disable iff (!rst_n)
		issue_valid |-> cnt_w'(sel) < count && e_rdy1[sel] && e_rdy2[sel]);

endmodule

`default_nettype wire

// File: design/reorder_buffer.sv
`default_nettype none

module reorder_buffer #(
	parameter int rob_depth = 8
) (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         alloc,
	input  ooo_cfg_pkg::areg_t           alloc_rd,
	input  logic [$clog2(rob_depth)-1:0] rd1_tag,
	input  logic [$clog2(rob_depth)-1:0] rd2_tag,
	input  logic                         cdb_valid,
	input  logic [$clog2(rob_depth)-1:0] cdb_tag,
	input  ooo_cfg_pkg::data_t           cdb_data,
	output logic                         full,
	output logic [$clog2(rob_depth)-1:0] tail,
	output logic                         rd1_ready,
	output ooo_cfg_pkg::data_t           rd1_data,
	output logic                         rd2_ready,
	output ooo_cfg_pkg::data_t           rd2_data,
	output logic                         commit_valid,
	output ooo_cfg_pkg::areg_t           commit_rd,
	output ooo_cfg_pkg::data_t           commit_data,
	output logic [$clog2(rob_depth)-1:0] commit_tag
);
	import ooo_cfg_pkg::*;

	localparam int tag_w = $clog2(rob_depth);

	////////////////////////////////////////
	// pointers and per-slot state
	logic [tag_w-1:0]     head;
	logic [tag_w:0]       count;
	logic [rob_depth-1:0] e_valid;
	logic [rob_depth-1:0] e_ready;
	areg_t                e_rd   [rob_depth];
	data_t                e_data [rob_depth];

	assign full = (count == (tag_w + 1)'(rob_depth));

	// operand reads for dispatch
	assign rd1_ready = e_ready[rd1_tag];
	assign rd1_data  = e_data[rd1_tag];
	assign rd2_ready = e_ready[rd2_tag];
	assign rd2_data  = e_data[rd2_tag];

	// head leaves once its result is in
	assign commit_valid = e_valid[head] && e_ready[head];
	assign commit_rd    = e_rd[head];
	assign commit_data  = e_data[head];
	assign commit_tag   = head;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head    <= '0;
			tail    <= '0;
			count   <= '0;
			e_valid <= '0;
			e_ready <= '0;
		end else begin
			if (alloc) begin
				e_valid[tail] <= 1'b1;
				e_ready[tail] <= 1'b0;
				tail          <= tail + 1'b1;
			end
			// result written back
			if (cdb_valid) begin
				e_ready[cdb_tag] <= 1'b1;
			end
			if (commit_valid) begin
				e_valid[head] <= 1'b0;
				head          <= head + 1'b1;
			end
			count <= count + (tag_w + 1)'(alloc) - (tag_w + 1)'(commit_valid);
		end
	end

	// destination and result payload
	always_ff @(posedge clock) begin
		if (alloc) begin
			e_rd[tail] <= alloc_rd;
		end
		if (cdb_valid) begin
			e_data[cdb_tag] <= cdb_data;
		end
	end

	// a broadcast must name a live slot
	a_cdb_live: assert property (@(posedge clock) disable iff (!rst_n)
		cdb_valid |-> e_valid[cdb_tag]);

	// and complete it exactly once
	a_cdb_once: assert property (@(posedge clock) disable iff (!rst_n)
		cdb_valid |-> !e_ready[cdb_tag]);

endmodule

`default_nettype wire

// File: design/dispatch_rename.sv
`default_nettype none

module dispatch_rename #(
	parameter int rob_depth = 8
) (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         in_valid,
	input  ooo_uop_pkg::alu_op_t         in_op,
	input  ooo_cfg_pkg::areg_t           in_rd,
	input  ooo_cfg_pkg::areg_t           in_rs1,
	input  ooo_cfg_pkg::areg_t           in_rs2,
	input  ooo_cfg_pkg::data_t           in_imm,
	input  logic                         rob_full,
	input  logic                         rs_full,
	input  logic                         rob_rd1_ready,
	input  ooo_cfg_pkg::data_t           rob_rd1_data,
	input  logic                         rob_rd2_ready,
	input  ooo_cfg_pkg::data_t           rob_rd2_data,
	input  logic [$clog2(rob_depth)-1:0] rob_tail,
	input  logic                         cdb_valid,
	input  logic [$clog2(rob_depth)-1:0] cdb_tag,
	input  ooo_cfg_pkg::data_t           cdb_data,
	input  logic                         commit_valid,
	input  ooo_cfg_pkg::areg_t           commit_rd,
	input  ooo_cfg_pkg::data_t           commit_data,
	input  logic [$clog2(rob_depth)-1:0] commit_tag,
	output logic                         in_ready,
	output logic                         alloc,
	output logic [$clog2(rob_depth)-1:0] rob_rd1_tag,
	output logic [$clog2(rob_depth)-1:0] rob_rd2_tag,
	output logic                         src1_ready,
	output logic [$clog2(rob_depth)-1:0] src1_tag,
	output ooo_cfg_pkg::data_t           src1_data,
	output logic                         src2_ready,
	output logic [$clog2(rob_depth)-1:0] src2_tag,
	output ooo_cfg_pkg::data_t           src2_data
);
	import ooo_cfg_pkg::*;
	import ooo_uop_pkg::*;

	localparam int tag_w = $clog2(rob_depth);

	// architectural state and rename map
	data_t                arch_q    [arch_regs];
	logic [arch_regs-1:0] map_valid;
	logic [tag_w-1:0]     map_tag   [arch_regs];
	// low through reset, high from the first cycle after
	logic                 running;
	// tail slot still named by a live mapping
	logic                 tail_mapped;

	// zero reg, then arf, then finished rob entry, then cdb this cycle
	function automatic void resolve(
		input  areg_t            rs,
		input  logic             rob_rdy,
		input  data_t            rob_val,
		output logic             rdy,
		output logic [tag_w-1:0] tag,
		output data_t            val
	);
		rdy = 1'b1;
		tag = map_tag[rs];
		val = '0;
		if (rs == '0) begin
			tag = '0;
		end else if (!map_valid[rs]) begin
			tag = '0;
			val = arch_q[rs];
		end else if (rob_rdy) begin
			val = rob_val;
		end else if (cdb_valid && cdb_tag == map_tag[rs]) begin
			val = cdb_data;
		end else begin
			// wait on the producer tag
			rdy = 1'b0;
		end
	endfunction

	assign in_ready    = running && !rob_full && !rs_full;
	assign alloc       = in_valid && in_ready;
	assign rob_rd1_tag = map_tag[in_rs1];
	assign rob_rd2_tag = map_tag[in_rs2];

	always_comb begin
		resolve(in_rs1, rob_rd1_ready, rob_rd1_data, src1_ready, src1_tag, src1_data);
		resolve(in_rs2, rob_rd2_ready, rob_rd2_data, src2_ready, src2_tag, src2_data);
		// li has ready zero on source 1
		if (!uses_rs1(in_op)) begin
			src1_ready = 1'b1;
			src1_tag   = '0;
			src1_data  = '0;
		end
		// addi and li carry imm on source 2
		if (!uses_rs2(in_op)) begin
			src2_ready = 1'b1;
			src2_tag   = '0;
			src2_data  = in_imm;
		end
	end

	// any register whose producer sits in the tail slot
	always_comb begin
		tail_mapped = 1'b0;
		for (int i = 0; i < arch_regs; i++) begin
			if (map_valid[i] && map_tag[i] == rob_tail) begin
				tail_mapped = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			running   <= 1'b0;
			map_valid <= '0;
			for (int i = 0; i < arch_regs; i++) begin
				arch_q[i] <= '0;
			end
		end else begin
			running <= 1'b1;
			// retire into arf, r0 stays zero
			if (commit_valid && commit_rd != '0) begin
				arch_q[commit_rd] <= commit_data;
			end
			// drop mapping once its producer retires, unless renamed now
			if (commit_valid && map_valid[commit_rd] && map_tag[commit_rd] == commit_tag &&
					!(alloc && in_rd == commit_rd)) begin
				map_valid[commit_rd] <= 1'b0;
			end
			if (alloc && in_rd != '0) begin
				map_valid[in_rd] <= 1'b1;
			end
		end
	end

	// new producer of rd is the rob tail
	always_ff @(posedge clock) begin
		if (alloc) begin
			map_tag[in_rd] <= rob_tail;
		end
	end

	// a write into a slot that is still in flight means the rob had no room
	a_alloc_room: assert property (@(posedge clock) disable iff (!rst_n)
		alloc |-> !rob_full && !rs_full && !tail_mapped);

endmodule

`default_nettype wire

// File: design/ooo_core.sv
`default_nettype none

module ooo_core #(
	parameter int rob_depth = 8,
	parameter int rs_depth  = 4
) (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  ooo_uop_pkg::alu_op_t in_op,
	input  ooo_cfg_pkg::areg_t   in_rd,
	input  ooo_cfg_pkg::areg_t   in_rs1,
	input  ooo_cfg_pkg::areg_t   in_rs2,
	input  ooo_cfg_pkg::data_t   in_imm,
	output logic                 in_ready,
	output logic                 commit_valid,
	output ooo_cfg_pkg::areg_t   commit_rd,
	output ooo_cfg_pkg::data_t   commit_data
);
	import ooo_cfg_pkg::*;
	import ooo_uop_pkg::*;

	localparam int tag_w = $clog2(rob_depth);

	////////////////////////////////////////
	// dispatch entry write
	logic             alloc;
	logic             rob_full;
	logic             rs_full;
	logic [tag_w-1:0] rob_tail;
	logic [tag_w-1:0] rob_rd1_tag;
	logic [tag_w-1:0] rob_rd2_tag;
	logic             rob_rd1_ready;
	logic             rob_rd2_ready;
	data_t            rob_rd1_data;
	data_t            rob_rd2_data;
	logic             src1_ready;
	logic             src2_ready;
	logic [tag_w-1:0] src1_tag;
	logic [tag_w-1:0] src2_tag;
	data_t            src1_data;
	data_t            src2_data;

	// rs to alu
	logic             issue_valid;
	alu_op_t          issue_op;
	logic [tag_w-1:0] issue_tag;
	data_t            issue_a;
	data_t            issue_b;

	////////////////////////////////////////
	// cdb, single entry
	logic             cdb_valid;
	logic [tag_w-1:0] cdb_tag;
	data_t            cdb_data;

	// retiring rob slot
	logic [tag_w-1:0] commit_tag;

	dispatch_rename #(
		.rob_depth(rob_depth)
	) i_dispatch (
		.clock        (clock),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_op        (in_op),
		.in_rd        (in_rd),
		.in_rs1       (in_rs1),
		.in_rs2       (in_rs2),
		.in_imm       (in_imm),
		.rob_full     (rob_full),
		.rs_full      (rs_full),
		.rob_rd1_ready(rob_rd1_ready),
		.rob_rd1_data (rob_rd1_data),
		.rob_rd2_ready(rob_rd2_ready),
		.rob_rd2_data (rob_rd2_data),
		.rob_tail     (rob_tail),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_data     (cdb_data),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data),
		.commit_tag   (commit_tag),
		.in_ready     (in_ready),
		.alloc        (alloc),
		.rob_rd1_tag  (rob_rd1_tag),
		.rob_rd2_tag  (rob_rd2_tag),
		.src1_ready   (src1_ready),
		.src1_tag     (src1_tag),
		.src1_data    (src1_data),
		.src2_ready   (src2_ready),
		.src2_tag     (src2_tag),
		.src2_data    (src2_data)
	);

	// rd and op go straight to the rob and rs
	reorder_buffer #(
		.rob_depth(rob_depth)
	) i_rob (
		.clock       (clock),
		.rst_n       (rst_n),
		.alloc       (alloc),
		.alloc_rd    (in_rd),
		.rd1_tag     (rob_rd1_tag),
		.rd2_tag     (rob_rd2_tag),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_data    (cdb_data),
		.full        (rob_full),
		.tail        (rob_tail),
		.rd1_ready   (rob_rd1_ready),
		.rd1_data    (rob_rd1_data),
		.rd2_ready   (rob_rd2_ready),
		.rd2_data    (rob_rd2_data),
		.commit_valid(commit_valid),
		.commit_rd   (commit_rd),
		.commit_data (commit_data),
		.commit_tag  (commit_tag)
	);

	reservation_station #(
		.rs_depth (rs_depth),
		.rob_depth(rob_depth)
	) i_rs (
		.clock      (clock),
		.rst_n      (rst_n),
		.alloc      (alloc),
		.alloc_op   (in_op),
		.alloc_tag  (rob_tail),
		.src1_ready (src1_ready),
		.src1_tag   (src1_tag),
		.src1_data  (src1_data),
		.src2_ready (src2_ready),
		.src2_tag   (src2_tag),
		.src2_data  (src2_data),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_data   (cdb_data),
		.full       (rs_full),
		.issue_valid(issue_valid),
		.issue_op   (issue_op),
		.issue_tag  (issue_tag),
		.issue_a    (issue_a),
		.issue_b    (issue_b)
	);

	alu_pipe #(
		.rob_depth(rob_depth)
	) i_alu (
		.clock      (clock),
		.rst_n      (rst_n),
		.issue_valid(issue_valid),
		.issue_op   (issue_op),
		.issue_tag  (issue_tag),
		.issue_a    (issue_a),
		.issue_b    (issue_b),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_data   (cdb_data)
	);

endmodule

`default_nettype wire

// File: tb/ooo_ref.svh
`ifndef OOO_REF_SVH
`define OOO_REF_SVH

// sequential register model, r0 pinned to zero
data_t model_regs [arch_regs];

// result of one opcode on its operands
function automatic data_t alu_result(alu_op_t op, data_t a, data_t b, data_t imm);
	case (op)
		op_add:  return a + b;
		op_sub:  return a - b;
		op_and:  return a & b;
		op_xor:  return a ^ b;
		op_addi: return a + imm;
		op_li:   return imm;
		default: return '0;
	endcase
endfunction

// all model registers back to zero
function automatic void clear_model();
	for (int i = 0; i < arch_regs; i++) begin
		model_regs[i] = '0;
	end
endfunction

// r0 always reads zero
function automatic data_t read_model(areg_t r);
	return (r == '0) ? '0 : model_regs[r];
endfunction

// apply one op in program order, value that rd receives
function automatic data_t model_step(alu_op_t op, areg_t rd, areg_t rs1, areg_t rs2,
		data_t imm);
	data_t a;
	data_t b;
	data_t v;
	a = read_model(rs1);
	b = uses_rs2(op) ? read_model(rs2) : '0;
	v = alu_result(op, a, b, imm);
	if (rd != '0) begin
		model_regs[rd] = v;
	end
	return v;
endfunction

`endif

// File: tb/ooo_core_tb.sv
`default_nettype none

module ooo_core_tb;
	import ooo_cfg_pkg::*;
	import ooo_uop_pkg::*;

	`include "ooo_ref.svh"

	localparam int period        = 8;
	localparam int planned_ops   = 360;
	localparam int cycles_per_op = 12;
	// worst case per op plus reset and drain slack
	localparam int watchdog_time = (planned_ops * cycles_per_op + 200) * period;
	// longest wait for the rob to empty
	localparam int drain_cycles  = 200;

	logic    clock;
	logic    rst_n;
	logic    in_valid;
	alu_op_t in_op;
	areg_t   in_rd;
	areg_t   in_rs1;
	areg_t   in_rs2;
	data_t   in_imm;
	logic    in_ready;
	logic    commit_valid;
	areg_t   commit_rd;
	data_t   commit_data;

	////////////////////////////////////////
	// scoreboard state
	areg_t   exp_rd   [$];
	data_t   exp_data [$];
	areg_t   want_rd;
	data_t   want_data;
	logic    took;
	int      errors;
	int      stalls;
	int      stalls_before;
	int      seed;
	alu_op_t r_op;
	int      gap;

	ooo_core #(
		.rob_depth(8),
		.rs_depth (4)
	) i_dut (
		.clock       (clock),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_op       (in_op),
		.in_rd       (in_rd),
		.in_rs1      (in_rs1),
		.in_rs2      (in_rs2),
		.in_imm      (in_imm),
		.in_ready    (in_ready),
		.commit_valid(commit_valid),
		.commit_rd   (commit_rd),
		.commit_data (commit_data)
	);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// record acceptances and compare commits
	always @(posedge clock) begin
		took = in_valid && in_ready;
		if (rst_n) begin
			if (commit_valid) begin
				assert (exp_rd.size() != 0) else begin
					errors++;
					$display("error: commit of r%0d at time %0t with no micro-op outstanding",
						commit_rd, $time);
				end
				if (exp_rd.size() != 0) begin
					want_rd   = exp_rd.pop_front();
					want_data = exp_data.pop_front();
					assert (commit_rd == want_rd && commit_data == want_data) else begin
						errors++;
						$display("FAIL %0t: commit r%0d = %h, expected r%0d = %h",
							$time, commit_rd, commit_data, want_rd, want_data);
					end
				end
			end
			// expected value in acceptance order
			if (took) begin
				exp_rd.push_back(in_rd);
				exp_data.push_back(model_step(in_op, in_rd, in_rs1, in_rs2, in_imm));
			end
			if (in_valid && !in_ready) begin
				stalls++;
			end
		end
	end

	// hold one op until it transfers
	task automatic send_op(alu_op_t op, areg_t rd, areg_t rs1, areg_t rs2, data_t imm);
		in_valid = 1'b1;
		in_op    = op;
		in_rd    = rd;
		in_rs1   = rs1;
		in_rs2   = rs2;
		in_imm   = imm;
		do begin
			@(posedge clock);
			#1;
		end while (!took);
		in_valid = 1'b0;
	endtask

	task automatic idle(int n);
		in_valid = 1'b0;
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// wait for every accepted op to retire, bounded
	task automatic drain();
		int waited;
		waited = 0;
		while (exp_rd.size() != 0 && waited < drain_cycles) begin
			@(posedge clock);
			#1;
			waited++;
		end
		idle(10);
	endtask

	////////////////////////////////////////
	// stimulus
	initial begin
		errors   = 0;
		stalls   = 0;
		seed     = 32'h6d88;
		took     = 1'b0;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_op    = op_add;
		in_rd    = '0;
		in_rs1   = '0;
		in_rs2   = '0;
		in_imm   = '0;
		clear_model();

		repeat (10) @(posedge clock);
		#1;
		assert (!in_ready && !commit_valid) else begin
			errors++;
			$display("error: in_ready or commit_valid high during reset");
		end
		rst_n = 1'b1;
		@(posedge clock);
		#1;
		assert (in_ready) else begin
			errors++;
			$display("error: in_ready did not rise on the first cycle out of reset");
		end
		// quiet period, any commit here is flagged
		idle(5);

		// dependent chain, back to back
		send_op(op_li, 4'd1, 4'd0, 4'd0, 32'd5);
		send_op(op_li, 4'd2, 4'd0, 4'd0, 32'd7);
		send_op(op_add, 4'd3, 4'd1, 4'd2, 32'd0);
		send_op(op_sub, 4'd4, 4'd3, 4'd1, 32'd0);
		send_op(op_and, 4'd5, 4'd4, 4'd3, 32'd0);
		send_op(op_xor, 4'd6, 4'd5, 4'd2, 32'd0);
		send_op(op_addi, 4'd7, 4'd6, 4'd0, 32'd100);
		send_op(op_add, 4'd8, 4'd7, 4'd7, 32'd0);
		// same chain spaced out so dispatch sees finished values
		send_op(op_li, 4'd1, 4'd0, 4'd0, 32'hdead_beef);
		idle(2);
		send_op(op_addi, 4'd2, 4'd1, 4'd0, 32'hffff_ffff);
		idle(1);
		send_op(op_xor, 4'd3, 4'd2, 4'd1, 32'd0);
		idle(3);
		send_op(op_sub, 4'd4, 4'd0, 4'd3, 32'd0);
		drain();

		// r0 writes commit but never stick
		send_op(op_li, 4'd0, 4'd0, 4'd0, 32'h55);
		send_op(op_addi, 4'd9, 4'd0, 4'd0, 32'd3);
		send_op(op_add, 4'd10, 4'd0, 4'd8, 32'd0);
		send_op(op_add, 4'd0, 4'd8, 4'd8, 32'd0);
		send_op(op_xor, 4'd11, 4'd0, 4'd0, 32'd0);
		drain();

		// burst of dependent ops, in_valid stays high
		stalls_before = stalls;
		for (int i = 0; i < 24; i++) begin
			send_op((i % 3 == 0) ? op_addi : op_add, areg_t'(1 + (i % 7)),
				areg_t'(1 + ((i + 6) % 7)), areg_t'(1 + ((i + 3) % 7)), 32'(i));
		end
		drain();
		assert (stalls > stalls_before) else begin
			errors++;
			$display("error: in_ready never fell during the burst");
		end

		// random ops with random gaps
		for (int n = 0; n < 300; n++) begin
			r_op = alu_op_t'(3'($unsigned($random(seed)) % 6));
			send_op(r_op, areg_t'($random(seed)), areg_t'($random(seed)),
				areg_t'($random(seed)), data_t'($random(seed)));
			gap = int'($unsigned($random(seed)) % 4);
			if (gap != 0) begin
				idle(gap);
			end
		end
		drain();

		assert (exp_rd.size() == 0) else begin
			errors++;
			$display("error: %0d accepted micro-ops never committed", exp_rd.size());
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// hang guard
	initial begin
		#(watchdog_time);
		$display("error: watchdog expired with %0d micro-ops outstanding", exp_rd.size());
		$display("errors: %0d", errors + 1);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tb
design/ooo_cfg_pkg.sv
design/ooo_uop_pkg.sv
design/alu_pipe.sv
design/reservation_station.sv
design/reorder_buffer.sv
design/dispatch_rename.sv
design/ooo_core.sv
tb/ooo_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ooo core testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module ooo_core_tb -o ooo_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/ooo_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides pass or fail
if grep -qx "Finished with no errors" sim.log; then
	exit 0
fi
exit 1
